// File: pht_pkg.sv
// pht_pkg: pht widths, table geometry, counter/row types, pc union, request and update structs
package pht_pkg;

    // --------------------
    // widths
    localparam int ASID_WIDTH      = 9;
    localparam int GH_WIDTH        = 12;
    localparam int FETCH_IDX_WIDTH = 6;
    localparam int LANE_WIDTH      = 3;
    localparam int PC_WIDTH        = 38;
    // pc bits above the fetch index
    localparam int PC_UPPER_WIDTH  = PC_WIDTH - FETCH_IDX_WIDTH - LANE_WIDTH;

    // --------------------
    // table geometry
    localparam int INDEX_WIDTH   = 6;
    localparam int SETS          = 1 << INDEX_WIDTH;
    localparam int LANES         = 1 << LANE_WIDTH;
    localparam int COUNTER_WIDTH = 2;
    // asid bits above the index width, folded back in
    localparam int ASID_HI_WIDTH = ASID_WIDTH - INDEX_WIDTH;

    // --------------------
    // scalar types
    typedef logic [ASID_WIDTH-1:0]      asid_t;
    typedef logic [GH_WIDTH-1:0]        gh_t;
    typedef logic [FETCH_IDX_WIDTH-1:0] fetch_idx_t;
    typedef logic [LANE_WIDTH-1:0]      fetch_lane_t;
    typedef logic [INDEX_WIDTH-1:0]     pht_index_t;
    typedef logic [COUNTER_WIDTH-1:0]   counter_t;

    // counter end points
    localparam counter_t COUNTER_INIT = 2'd1;   // weakly not-taken
    localparam counter_t COUNTER_MIN  = 2'd0;
    localparam counter_t COUNTER_MAX  = 2'd3;

    // one set, one counter per fetch lane
    typedef counter_t [LANES-1:0] pht_row_t;

    // --------------------
    // pc views
    typedef struct packed {
        logic [PC_UPPER_WIDTH-1:0] upper;
        fetch_idx_t                fetch_idx;   // pc[8:3]
        fetch_lane_t               lane;        // pc[2:0]
    } pc38_fields_t;

    typedef union packed {
        logic [PC_WIDTH-1:0] raw;
        pc38_fields_t        fields;
    } pc38_u;

    // --------------------
    // request and update bundles
    typedef struct packed {
        fetch_idx_t fetch_idx;
        gh_t        gh;
    } pht_read_req_t;

    typedef struct packed {
        pc38_u pc;
        gh_t   gh;
        logic  taken;
    } pht_update_t;

endpackage

// File: pht_index_hash.sv
// pht_index_hash: gshare fold of fetch index, history and asid into read and update set indexes
`timescale 1ns/1ps

module pht_index_hash
    import pht_pkg::*;
(
    input  asid_t         arch_asid,
    input  pht_read_req_t read_req,
    input  pht_update_t   update,
    output pht_index_t    read_index,
    output pht_index_t    update_index
);

    // --------------------
    // folding

    // index ^ (gh hi ^ gh lo) ^ (asid lo ^ asid hi)
    function automatic pht_index_t fold_index(
        input fetch_idx_t idx,
        input gh_t        gh,
        input asid_t      asid
    );
        pht_index_t gh_fold;
        pht_index_t asid_fold;
        begin
            // both history halves are index wide
            gh_fold   = gh[GH_WIDTH-1 -: INDEX_WIDTH] ^ gh[INDEX_WIDTH-1:0];
            // top asid bits zero-extended onto the low ones
            asid_fold = asid[INDEX_WIDTH-1:0]
                      ^ {{(INDEX_WIDTH-ASID_HI_WIDTH){1'b0}},
                         asid[ASID_WIDTH-1 -: ASID_HI_WIDTH]};
            fold_index = pht_index_t'(idx) ^ gh_fold ^ asid_fold;
        end
    endfunction

    // --------------------
    // index paths

    // update pc decoded through its field view
    fetch_idx_t update_fetch_idx;
    assign update_fetch_idx = update.pc.fields.fetch_idx;

    // read side
    assign read_index   = fold_index(read_req.fetch_idx, read_req.gh, arch_asid);

    // update side, same asid
    assign update_index = fold_index(update_fetch_idx, update.gh, arch_asid);

endmodule

// File: pht_counter_array.sv
// pht_counter_array: 64x8 saturating counter table, registered row read, read-modify-write update
`timescale 1ns/1ps

module pht_counter_array
    import pht_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        read_req_valid,
    input  pht_index_t  read_index,
    input  logic        update_valid,
    input  pht_index_t  update_index,
    input  fetch_lane_t update_lane,
    input  logic        update_taken,
    output pht_row_t    read_row
);

    // --------------------
    // storage
    pht_row_t table_q [SETS];

    // trained counter before and after the step
    counter_t upd_cnt_old;
    counter_t upd_cnt_new;

    assign upd_cnt_old = table_q[update_index][update_lane];

    // saturating step toward the outcome
    always_comb begin
        if (update_taken) begin
            if (upd_cnt_old == COUNTER_MAX) begin
                upd_cnt_new = COUNTER_MAX;
            end else begin
                upd_cnt_new = upd_cnt_old + 2'd1;
            end
        end else begin
            if (upd_cnt_old == COUNTER_MIN) begin
                upd_cnt_new = COUNTER_MIN;
            end else begin
                upd_cnt_new = upd_cnt_old - 2'd1;
            end
        end
    end

    // --------------------
    // table and row register
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // every counter starts weakly not-taken
            for (int s = 0; s < SETS; s++) begin
                table_q[s] <= {LANES{COUNTER_INIT}};
            end
            read_row <= '0;
        end else begin
            // row sees contents from before this edge's write
            if (read_req_valid) begin
                read_row <= table_q[read_index];
            end
            if (update_valid) begin
                table_q[update_index][update_lane] <= upd_cnt_new;
            end
        end
    end

    // --------------------
    // checks

    // indexes from the hash must be clean when used
    a_read_index_known: assert property (@(posedge CLK) disable iff (!nRST)
        read_req_valid |-> !$isunknown(read_index));

    a_update_index_known: assert property (@(posedge CLK) disable iff (!nRST)
        update_valid |-> !$isunknown({update_index, update_lane, update_taken}));

    // every counter of a loaded row stays within 0..3
    a_row_in_range: assert property (@(posedge CLK) disable iff (!nRST)
        read_req_valid |=> !$isunknown(read_row));

endmodule

// File: pht_resp_select.sv
// pht_resp_select: redirect lane counter pick from the read row and the taken bit
`timescale 1ns/1ps

module pht_resp_select
    import pht_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    input  logic        read_req_valid,
    input  pht_row_t    read_row,
    input  fetch_lane_t redirect_lane,
    output logic        taken
);

    // set once the array has loaded a row
    logic row_loaded;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            row_loaded <= 1'b0;
        end else if (read_req_valid) begin
            row_loaded <= 1'b1;
        end
    end

    // counter msb is the direction
    assign taken = row_loaded & read_row[redirect_lane][COUNTER_WIDTH-1];

    // lane comes from the wrapper stage and must be driven once rows exist
    a_lane_known: assert property (@(posedge CLK) disable iff (!nRST)
        row_loaded |-> !$isunknown(redirect_lane));

endmodule

// File: pht_wrapper.sv
// pht_wrapper: pht top with input/output register stage around hash, counter array and lane select
`timescale 1ns/1ps

module pht_wrapper
    import pht_pkg::*;
(
    // seq
    input  logic          CLK,
    input  logic          nRST,

    // arch state
    input  asid_t         next_arch_asid,

    // read req stage
    input  logic          next_read_req_valid,
    input  pht_read_req_t next_read_req,

    // read resp stage
    input  fetch_lane_t   next_read_resp_redirect_lane,
    output logic          last_read_resp_taken,

    // update
    input  logic          next_update_valid,
    input  pht_update_t   next_update
);

    // --------------------
    // registered inputs

    asid_t         arch_asid;
    logic          read_req_valid;
    pht_read_req_t read_req;
    fetch_lane_t   read_resp_redirect_lane;
    logic          update_valid;
    pht_update_t   update;

    // --------------------
    // internal links

    pht_index_t read_index;
    pht_index_t update_index;
    pht_row_t   read_row;
    logic       read_resp_taken;

    // --------------------
    // blocks

    // set index for both paths
    pht_index_hash hash_i (
        .arch_asid    (arch_asid),
        .read_req     (read_req),
        .update       (update),
        .read_index   (read_index),
        .update_index (update_index)
    );

    // lane and outcome straight out of the update bundle
    pht_counter_array array_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_req_valid (read_req_valid),
        .read_index     (read_index),
        .update_valid   (update_valid),
        .update_index   (update_index),
        .update_lane    (update.pc.fields.lane),
        .update_taken   (update.taken),
        .read_row       (read_row)
    );

    // lane pick one cycle after the row load
    pht_resp_select select_i (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_req_valid (read_req_valid),
        .read_row       (read_row),
        .redirect_lane  (read_resp_redirect_lane),
        .taken          (read_resp_taken)
    );

    // --------------------
    // wrapper registers
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            arch_asid               <= '0;
            read_req_valid          <= 1'b0;
            read_req                <= '0;
            read_resp_redirect_lane <= '0;
            last_read_resp_taken    <= 1'b0;
            update_valid            <= 1'b0;
            update                  <= '0;
        end else begin
            arch_asid               <= next_arch_asid;
            read_req_valid          <= next_read_req_valid;
            read_req                <= next_read_req;
            read_resp_redirect_lane <= next_read_resp_redirect_lane;
            // response leaves two edges after the request
            last_read_resp_taken    <= read_resp_taken;
            update_valid            <= next_update_valid;
            update                  <= next_update;
        end
    end

endmodule

// File: tb_pht_wrapper.sv
// tb_pht_wrapper: clock, reset, seeded random reads and updates, counter table model, checks
`timescale 1ns/1ps

module tb_pht_wrapper
    import pht_pkg::*;
();

    // --------------------
    // run length
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_READS      = 8;
    // idle reads at 3 cycles each, then trained counter, pipelining, same-edge, hash tests
    localparam int DIRECTED_CYCLES = 3 * IDLE_READS + 18 + 6 + 4 + 11;
    localparam int N_RANDOM        = 400;
    localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM + 2;
    localparam int MAX_CYCLES      = TEST_CYCLES + 20;

    // --------------------
    // dut signals
    logic          CLK = 1'b0;
    logic          nRST;
    asid_t         next_arch_asid;
    logic          next_read_req_valid;
    pht_read_req_t next_read_req;
    fetch_lane_t   next_read_resp_redirect_lane;
    logic          next_update_valid;
    pht_update_t   next_update;
    logic          last_read_resp_taken;

    // --------------------
    // model state
    pht_row_t   model_tbl [SETS];
    pht_row_t   model_row;
    logic       model_loaded;
    // row requested on the last edge, loaded on the next
    logic       pend_valid;
    pht_row_t   pend_row;
    // expected response and whether a read stands behind it
    logic       exp_taken_q [$];
    logic       exp_check_q [$];
    integer     seed;
    int         cycles = 0;
    fetch_idx_t idx_a;
    fetch_idx_t idx_b;
    logic [31:0] r;
    logic [31:0] r2;

    pht_wrapper dut_i (
        .CLK                          (CLK),
        .nRST                         (nRST),
        .next_arch_asid               (next_arch_asid),
        .next_read_req_valid          (next_read_req_valid),
        .next_read_req                (next_read_req),
        .next_read_resp_redirect_lane (next_read_resp_redirect_lane),
        .last_read_resp_taken         (last_read_resp_taken),
        .next_update_valid            (next_update_valid),
        .next_update                  (next_update)
    );

    always #20 CLK = ~CLK;

    // abort if the sequence stalls
    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // helpers
    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    // gshare fold, written out from the index rule
    function automatic pht_index_t hash_index(
        input fetch_idx_t idx,
        input gh_t        gh,
        input asid_t      asid
    );
        pht_index_t g;
        pht_index_t a;
        begin
            g = gh[11:6] ^ gh[5:0];
            a = asid[5:0] ^ {3'b000, asid[8:6]};
            hash_index = idx ^ g ^ a;
        end
    endfunction

    function automatic counter_t sat_step(input counter_t c, input logic up);
        if (up) begin
            sat_step = (c == 2'd3) ? 2'd3 : c + 2'd1;
        end else begin
            sat_step = (c == 2'd0) ? 2'd0 : c - 2'd1;
        end
    endfunction

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        begin
            if (exp_val !== act_val) begin
                $display("FAIL %s expected 0x%0h actual 0x%0h at %0t",
                         name, exp_val, act_val, $time);
                $display("Simulation FAILED");
                $fatal(1, "value mismatch");
            end
        end
    endtask

    // one sampling edge as the dut sees it
    task automatic model_edge();
        pht_index_t ri;
        pht_index_t ui;
        logic       resp;
        begin
            // row stage first
            if (pend_valid) begin
                model_row    = pend_row;
                model_loaded = 1'b1;
            end
            resp = model_loaded & model_row[next_read_resp_redirect_lane][1];
            exp_taken_q.push_back(resp);
            exp_check_q.push_back(pend_valid);
            // snapshot before this edge's update lands
            pend_valid = next_read_req_valid;
            ri = hash_index(next_read_req.fetch_idx, next_read_req.gh, next_arch_asid);
            pend_row = model_tbl[ri];
            if (next_update_valid) begin
                // pc[8:3] is the fetch index, pc[2:0] the lane
                ui = hash_index(next_update.pc.raw[8:3], next_update.gh, next_arch_asid);
                model_tbl[ui][next_update.pc.raw[2:0]] =
                    sat_step(model_tbl[ui][next_update.pc.raw[2:0]], next_update.taken);
            end
        end
    endtask

    // edge, model, check at +1 ns, return at +2 ns for the next drive
    task automatic tick();
        logic exp_val;
        logic chk;
        begin
            @(posedge CLK);
            model_edge();
            #1;
            exp_val = exp_taken_q.pop_front();
            chk     = exp_check_q.pop_front();
            if (chk) begin
                check_bit("last_read_resp_taken", exp_val, last_read_resp_taken);
            end
            #1;
        end
    endtask

    task automatic drive_idle();
        begin
            next_read_req_valid = 1'b0;
            next_update_valid   = 1'b0;
        end
    endtask

    task automatic drive_read(input fetch_idx_t idx, input gh_t gh);
        begin
            next_read_req_valid     = 1'b1;
            next_read_req.fetch_idx = idx;
            next_read_req.gh        = gh;
        end
    endtask

    task automatic drive_update(
        input fetch_idx_t  idx,
        input fetch_lane_t lane,
        input gh_t         gh,
        input logic        taken
    );
        logic [31:0] rv;
        begin
            rv = rand32();
            next_update_valid = 1'b1;
            // upper pc bits are noise to the hash
            next_update.pc.raw = {rv[28:0], idx, lane};
            next_update.gh     = gh;
            next_update.taken  = taken;
        end
    endtask

    task automatic train_counter(
        input fetch_idx_t  idx,
        input fetch_lane_t lane,
        input gh_t         gh,
        input logic        taken,
        input int          n
    );
        begin
            for (int i = 0; i < n; i++) begin
                drive_idle();
                drive_update(idx, lane, gh, taken);
                tick();
            end
            drive_idle();
        end
    endtask

    // request, lane one edge later, response after the second edge
    task automatic read_expect(
        input fetch_idx_t  idx,
        input gh_t         gh,
        input fetch_lane_t lane,
        input logic        exp_val
    );
        begin
            drive_idle();
            drive_read(idx, gh);
            tick();
            drive_idle();
            next_read_resp_redirect_lane = lane;
            tick();
            tick();
            check_bit("last_read_resp_taken", exp_val, last_read_resp_taken);
        end
    endtask

    // --------------------
    // stimulus
    initial begin
        seed                         = 32'h4d4c494e;
        nRST                         = 1'b0;
        next_arch_asid               = '0;
        next_read_req_valid          = 1'b0;
        next_read_req                = '0;
        next_read_resp_redirect_lane = '0;
        next_update_valid            = 1'b0;
        next_update                  = '0;
        for (int s = 0; s < SETS; s++) begin
            model_tbl[s] = {LANES{2'd1}};
        end
        model_row    = '0;
        model_loaded = 1'b0;
        pend_valid   = 1'b0;
        pend_row     = '0;
        // output register before the first edge
        exp_taken_q.push_back(1'b0);
        exp_check_q.push_back(1'b0);

        repeat (RESET_CYCLES) @(posedge CLK);
        #2;
        nRST = 1'b1;
        check_bit("last_read_resp_taken", 1'b0, last_read_resp_taken);

        // untouched table reads weakly not-taken everywhere
        for (int i = 0; i < IDLE_READS; i++) begin
            r = rand32();
            next_arch_asid = r[8:0];
            read_expect(r[14:9], r[26:15], r[29:27], 1'b0);
        end

        // one counter trained up, saturated, then walked back
        next_arch_asid = '0;
        read_expect(6'd5, '0, 3'd3, 1'b0);
        train_counter(6'd5, 3'd3, '0, 1'b1, 1);
        read_expect(6'd5, '0, 3'd3, 1'b1);
        train_counter(6'd5, 3'd3, '0, 1'b1, 3);
        train_counter(6'd5, 3'd3, '0, 1'b0, 1);
        read_expect(6'd5, '0, 3'd3, 1'b1);
        train_counter(6'd5, 3'd3, '0, 1'b0, 1);
        read_expect(6'd5, '0, 3'd3, 1'b0);

        // back to back reads of set 20 (taken) and set 21 (not)
        train_counter(6'd20, 3'd2, '0, 1'b1, 2);
        drive_read(6'd20, '0);
        tick();
        drive_read(6'd21, '0);
        next_read_resp_redirect_lane = 3'd2;
        tick();
        drive_idle();
        tick();
        check_bit("last_read_resp_taken", 1'b1, last_read_resp_taken);
        tick();
        check_bit("last_read_resp_taken", 1'b0, last_read_resp_taken);

        // update and read of set 9 lane 6 on one edge, then a read one edge later
        drive_update(6'd9, 3'd6, '0, 1'b1);
        drive_read(6'd9, '0);
        tick();
        drive_idle();
        drive_read(6'd9, '0);
        next_read_resp_redirect_lane = 3'd6;
        tick();
        drive_idle();
        tick();
        check_bit("last_read_resp_taken", 1'b0, last_read_resp_taken);
        tick();
        check_bit("last_read_resp_taken", 1'b1, last_read_resp_taken);

        // set 0x34 trained under one asid and history
        next_arch_asid = 9'h0C0;
        idx_a = 6'h34 ^ hash_index('0, 12'h0A5, 9'h0C0);
        train_counter(idx_a, 3'd7, 12'h0A5, 1'b1, 2);
        // neighbouring asid moves to set 0x35
        next_arch_asid = 9'h0C1;
        read_expect(idx_a, 12'h0A5, 3'd7, 1'b0);
        // so does one history bit
        next_arch_asid = 9'h0C0;
        read_expect(idx_a, 12'h0A4, 3'd7, 1'b0);
        // other asid and history, index chosen to land on 0x34 again
        next_arch_asid = 9'h1F3;
        idx_b = 6'h34 ^ hash_index('0, 12'h5C3, 9'h1F3);
        read_expect(idx_b, 12'h5C3, 3'd7, 1'b1);

        // --------------------
        // random mix, narrow fields so sets collide
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = rand32();
            r2 = rand32();
            // bit 8 folds into the high asid part, bit 0 into the low
            next_arch_asid               = {r[1], 7'd0, r[0]};
            next_read_req_valid          = r[2];
            next_read_req.fetch_idx      = {3'd0, r[5:3]};
            next_read_req.gh             = {8'd0, r[12:9]};
            next_read_resp_redirect_lane = r[15:13];
            next_update_valid            = r[16];
            next_update.pc.raw           = {r2[28:0], 3'd0, r[8:6], r2[31:29]};
            next_update.gh               = {8'd0, r[20:17]};
            next_update.taken            = r[21];
            tick();
        end
        // drain the last two reads
        drive_idle();
        tick();
        tick();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: all.f
pht_pkg.sv
pht_index_hash.sv
pht_counter_array.sv
pht_resp_select.sv
pht_wrapper.sv
tb_pht_wrapper.sv

// File: Makefile
# Verilator build and run of the pht testbench

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_pht_wrapper
FILELIST := all.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
